/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fft_stage
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST)) src/twiddle_table.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+src
src/fft_pkg.sv
src/twiddle_rom.sv
src/twiddle_arbiter.sv
src/butterfly_lane.sv
src/fft_stage_top.sv
dv/fft_stage_props.sv
dv/tb_fft_stage.sv

/* dv/fft_stage_props.sv */
`timescale 1ns/1ps

module fft_stage_props (
   input logic       clk,
   input logic       arst_n,
   input logic [1:0] tw_req,  // lane requests
   input logic [1:0] tw_ack,  // arbiter acks
   input logic       rd_en    // rom strobe
);

   // never two lanes served at once
   ack_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(tw_ack))
      else $error("tw_ack has both bits set");

   // ack only toward a lane that is asking
   ack0_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(tw_ack[0]) |-> tw_req[0])
      else $error("tw_ack[0] rose without tw_req[0]");

   ack1_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(tw_ack[1]) |-> tw_req[1])
      else $error("tw_ack[1] rose without tw_req[1]");

   // single read per grant
   rd_en_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      rd_en |=> !rd_en)
      else $error("rd_en high for more than one cycle");

   ack0_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (tw_ack[0] && tw_req[0]) |=> tw_ack[0])
      else $error("tw_ack[0] fell while tw_req[0] still high");

   ack1_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (tw_ack[1] && tw_req[1]) |=> tw_ack[1])
      else $error("tw_ack[1] fell while tw_req[1] still high");

endmodule

bind twiddle_arbiter fft_stage_props i_fft_stage_props (
   .clk    (clk),
   .arst_n (arst_n),
   .tw_req (tw_req),
   .tw_ack (tw_ack),
   .rd_en  (rd_en)
);

/* dv/tb_fft_stage.sv */
`timescale 1ns/1ps

module tb_fft_stage;
   import fft_pkg::*;

   `include "twiddle_table.svh"

   localparam int fft_n       = 32;             // own copy of the dut setting
   localparam int tb_stride   = max_n / fft_n;  // table step per k
   localparam int ack_timeout = 200;            // cycles per wait

   logic               clk;
   logic               arst_n;
   logic [1:0]         job_req;
   bfly_job_t          job0;
   bfly_job_t          job1;
   logic [1:0]         job_ack;
   bfly_res_t          res0;
   bfly_res_t          res1;

   integer    seed;           // $random state
   integer    err_cnt;        // all failed checks
   integer    test_cnt;
   integer    test_fail;      // tests with at least one error
   integer    test_err0;      // err_cnt at test start
   integer    done_cnt [0:1]; // results checked per lane
   logic [1:0] ack_seen;      // job_ack at previous falling edge
   bfly_res_t exp_q0 [$];     // expected results, lane 0
   bfly_res_t exp_q1 [$];

   fft_stage_top #(
      .fft_n (fft_n)
   ) i_fft_stage_top (
      .clk     (clk),
      .arst_n  (arst_n),
      .job_req (job_req),
      .job0    (job0),
      .job1    (job1),
      .job_ack (job_ack),
      .res0    (res0),
      .res1    (res1)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;  // 100 ns period

   // w = cos - j*sin, t = w*b floored to sample scale, outputs halved
   function automatic bfly_res_t bfly_ref(input bfly_job_t j);
      integer    idx;
      integer    c;
      integer    s;
      integer    tr;
      integer    ti;
      bfly_res_t r;
      idx = (j.k * tb_stride) % (max_n / 2);
      c   = tw_cos_tab[idx];
      s   = tw_sin_tab[idx];
      tr  = ($signed(j.b.re) * c + $signed(j.b.im) * s) >>> tw_frac;
      ti  = ($signed(j.b.im) * c - $signed(j.b.re) * s) >>> tw_frac;
      r.x0.re = data_w'(($signed(j.a.re) + tr) >>> 1);  // floor, then wrap
      r.x0.im = data_w'(($signed(j.a.im) + ti) >>> 1);
      r.x1.re = data_w'(($signed(j.a.re) - tr) >>> 1);
      r.x1.im = data_w'(($signed(j.a.im) - ti) >>> 1);
      return r;
   endfunction

   function automatic bfly_job_t make_job(input integer ar, input integer ai,
                                          input integer br, input integer bi,
                                          input integer k);
      bfly_job_t j;
      j.a.re = data_w'(ar);
      j.a.im = data_w'(ai);
      j.b.re = data_w'(br);
      j.b.im = data_w'(bi);
      j.k    = ang_w'(k);
      return j;
   endfunction

   function automatic bfly_job_t rand_job();
      bfly_job_t j;
      j.a.re = data_w'($random(seed));
      j.a.im = data_w'($random(seed));
      j.b.re = data_w'($random(seed));
      j.b.im = data_w'($random(seed));
      j.k    = ang_w'($random(seed));  // any angle of the half turn
      return j;
   endfunction

   task automatic compare_field(input string name, input logic [data_w-1:0] got,
                                input logic [data_w-1:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s exp 0x%04h got 0x%04h", name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_arrival(input int lane, input bfly_res_t got);
      bfly_res_t exp;
      if ((lane == 0 && exp_q0.size() == 0) || (lane == 1 && exp_q1.size() == 0)) begin
         $display("lane %0d raised job_ack with no job outstanding", lane);
         err_cnt++;
      end else begin
         exp = (lane == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
         compare_field($sformatf("res%0d.x0.re", lane), got.x0.re, exp.x0.re);
         compare_field($sformatf("res%0d.x0.im", lane), got.x0.im, exp.x0.im);
         compare_field($sformatf("res%0d.x1.re", lane), got.x1.re, exp.x1.re);
         compare_field($sformatf("res%0d.x1.im", lane), got.x1.im, exp.x1.im);
         done_cnt[lane]++;
      end
   endtask

   // result checker, outputs are settled at the falling edge
   always @(negedge clk) begin
      if (arst_n) begin
         if (job_ack[0] && !ack_seen[0]) begin
            check_arrival(0, res0);
         end
         if (job_ack[1] && !ack_seen[1]) begin
            check_arrival(1, res1);
         end
      end
      ack_seen = job_ack;
   end

   // one full four-phase job, hold = extra cycles with job_req kept high
   task automatic run_job(input int lane, input bfly_job_t j, input int hold);
      int        t;
      logic      seen;
      bfly_res_t snap;
      bfly_res_t cur;
      @(negedge clk);
      if (lane == 0) begin
         job0 = j;
         exp_q0.push_back(bfly_ref(j));
      end else begin
         job1 = j;
         exp_q1.push_back(bfly_ref(j));
      end
      job_req[lane] = 1'b1;
      seen = 1'b0;
      t    = 0;
      while (!seen && t < ack_timeout) begin
         @(negedge clk);
         seen = job_ack[lane];
         t++;
      end
      if (!seen) begin
         $display("timeout, lane %0d never raised job_ack", lane);
         err_cnt++;
         if (lane == 0 && exp_q0.size() > 0) void'(exp_q0.pop_back());  // stale entry
         if (lane == 1 && exp_q1.size() > 0) void'(exp_q1.pop_back());
      end else begin
         snap = (lane == 0) ? res0 : res1;
         for (int h = 0; h < hold; h++) begin
            @(negedge clk);
            cur = (lane == 0) ? res0 : res1;
            if (job_ack[lane] !== 1'b1) begin
               $display("[FAIL] job_ack[%0d] exp 0x1 got 0x%0h", lane, job_ack[lane]);
               err_cnt++;
            end
            if (cur !== snap) begin
               $display("[FAIL] res%0d exp 0x%014h got 0x%014h", lane, snap, cur);
               err_cnt++;
            end
         end
      end
      job_req[lane] = 1'b0;
      t = 0;
      while (job_ack[lane] && t < ack_timeout) begin  // wait for the ack to fall
         @(negedge clk);
         t++;
      end
      if (job_ack[lane]) begin
         $display("timeout, lane %0d kept job_ack high after job_req fell", lane);
         err_cnt++;
      end
   endtask

   task automatic start_test();
      test_cnt++;
      test_err0 = err_cnt;
   endtask

   task automatic finish_test(input string name);
      if (err_cnt == test_err0) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
         test_fail++;
      end
   endtask

   initial begin
      bfly_job_t j0;
      bfly_job_t j1;
      integer    d0;
      integer    d1;
      seed      = 59;
      err_cnt   = 0;
      test_cnt  = 0;
      test_fail = 0;
      done_cnt[0] = 0;
      done_cnt[1] = 0;
      ack_seen  = 2'b00;
      arst_n    = 1'b0;
      job_req   = 2'b00;
      job0      = '0;
      job1      = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      start_test();  // reset values
      @(negedge clk);
      if (job_ack !== 2'b00) begin
         $display("[FAIL] job_ack exp 0x0 got 0x%0h", job_ack);
         err_cnt++;
      end
      if (res0 !== '0) begin
         $display("[FAIL] res0 exp 0x0 got 0x%014h", res0);
         err_cnt++;
      end
      if (res1 !== '0) begin
         $display("[FAIL] res1 exp 0x0 got 0x%014h", res1);
         err_cnt++;
      end
      finish_test("reset state");

      start_test();
      run_job(0, make_job(1000, -500, 2000, 300, 0), 0);
      run_job(0, make_job(-1234, 777, -3000, 2500, 4), 0);
      run_job(0, make_job(4000, 123, 1500, -6000, 8), 0);  // k=8 is -j
      finish_test("lane 0 fixed jobs");

      start_test();
      for (int i = 0; i < 50; i++) begin
         run_job(1, rand_job(), 0);
      end
      finish_test("lane 1 random jobs");

      start_test();
      d0 = done_cnt[0];
      d1 = done_cnt[1];
      for (int i = 0; i < 50; i++) begin
         j0 = rand_job();
         j1 = rand_job();
         fork  // both requests rise on the same edge
            run_job(0, j0, 0);
            run_job(1, j1, 0);
         join
      end
      if (done_cnt[0] - d0 != 50 || done_cnt[1] - d1 != 50) begin
         $display("contention run completed %0d and %0d jobs instead of 50 each",
                  done_cnt[0] - d0, done_cnt[1] - d1);
         err_cnt++;
      end
      finish_test("both lanes contending");

      start_test();
      j0 = rand_job();
      fork  // lane 1 moves the shared twiddle bus while lane 0 holds
         run_job(0, j0, 20);
         for (int i = 0; i < 3; i++) begin
            run_job(1, rand_job(), 0);
         end
      join
      run_job(0, rand_job(), 0);  // next job after the long hold
      j1 = rand_job();
      fork
         run_job(1, j1, 20);
         for (int i = 0; i < 3; i++) begin
            run_job(0, rand_job(), 0);
         end
      join
      run_job(1, rand_job(), 0);
      finish_test("back-pressure");

      start_test();
      for (int k = 0; k < 16; k += 5) begin
         run_job(0, make_job(8191, 8191, 8191, 8191, k), 0);
         run_job(1, make_job(-8192, -8192, -8192, -8192, k), 0);
         run_job(0, make_job(8191, -8192, 8191, -8192, k), 0);
         run_job(1, make_job(-8192, 8191, -8192, 8191, k), 0);
      end
      finish_test("full-scale values");

      $display("%0d tests run, %0d with errors, %0d errors total",
               test_cnt, test_fail, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* src/butterfly_lane.sv */
`timescale 1ns/1ps

module butterfly_lane (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      job_req,  // four-phase job request
   input  fft_pkg::bfly_job_t        job,      // stable while job_req high
   output logic                      job_ack,
   output fft_pkg::bfly_res_t        res,      // valid while job_ack high
   output logic                      tw_req,   // twiddle request to arbiter
   output logic [fft_pkg::ang_w-1:0] tw_k,
   input  logic                      tw_ack,
   input  fft_pkg::twiddle_t         tw_data
);
   import fft_pkg::*;

   localparam int prod_w = data_w + tw_w + 1;  // sum of two products

   lane_state_t              state;
   bfly_job_t                job_q;     // latched job
   twiddle_t                 tw_q;      // latched twiddle
   logic signed [prod_w-1:0] t_re;      // re(w*b), q0 after shift
   logic signed [prod_w-1:0] t_im;      // im(w*b)
   logic signed [prod_w-1:0] s0_re;     // a + t
   logic signed [prod_w-1:0] s0_im;
   logic signed [prod_w-1:0] s1_re;     // a - t
   logic signed [prod_w-1:0] s1_im;
   bfly_res_t                res_next;  // result before the register

   assign tw_k = job_q.k;  // stable from idle until the next job

   // w*b with w = cos - j*sin, floor shift back to sample scale
   always_comb begin
      t_re = (job_q.b.re * tw_q.cos + job_q.b.im * tw_q.sin) >>> tw_frac;
      t_im = (job_q.b.im * tw_q.cos - job_q.b.re * tw_q.sin) >>> tw_frac;
      s0_re = job_q.a.re + t_re;
      s0_im = job_q.a.im + t_im;
      s1_re = job_q.a.re - t_re;
      s1_im = job_q.a.im - t_im;
      // halve with floor, keep data_w bits, no saturation
      res_next.x0.re = s0_re[data_w:1];
      res_next.x0.im = s0_im[data_w:1];
      res_next.x1.re = s1_re[data_w:1];
      res_next.x1.im = s1_im[data_w:1];
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= lane_idle;
         tw_req  <= 1'b0;
         job_ack <= 1'b0;
         res     <= '0;
      end else begin
         case (state)
            lane_idle: begin
               if (job_req) begin
                  tw_req <= 1'b1;  // ask for w(k) right away
                  state  <= lane_fetch;
               end
            end
            lane_fetch: begin
               if (tw_ack) begin
                  tw_req <= 1'b0;  // tw_q latched on this edge
                  state  <= lane_release;
               end
            end
            lane_release: begin
               if (!tw_ack) begin
                  state <= lane_compute;  // twiddle handshake closed
               end
            end
            lane_compute: begin
               res     <= res_next;
               job_ack <= 1'b1;
               state   <= lane_done;
            end
            lane_done: begin
               if (!job_req) begin
                  job_ack <= 1'b0;  // res held until here
                  state   <= lane_wait_drop;
               end
            end
            lane_wait_drop: begin
               // master sees job_ack low before the next job is taken
               state <= lane_idle;
            end
            default: begin
               state <= lane_idle;
            end
         endcase
      end
   end

   // operand registers
   always_ff @(posedge clk) begin
      if (state == lane_idle && job_req) begin
         job_q <= job;
      end
      if (state == lane_fetch && tw_ack) begin
         tw_q <= tw_data;
      end
   end

endmodule

/* src/fft_pkg.sv */
package fft_pkg;

   localparam int data_w  = 14;  // sample component width
   localparam int tw_w    = 14;  // twiddle width, q1.12
   localparam int tw_frac = 12;  // fraction bits, 1.0 = 4096
   localparam int max_n   = 32;  // native table transform size
   localparam int ang_w   = 4;   // angle index, covers max_n/2 entries

   // one complex sample
   typedef struct packed {
      logic signed [data_w-1:0] re;  // real part
      logic signed [data_w-1:0] im;  // imaginary part
   } cplx_t;

   // twiddle w = cos - j*sin
   typedef struct packed {
      logic signed [tw_w-1:0] cos;
      logic signed [tw_w-1:0] sin;
   } twiddle_t;

   typedef struct packed {
      cplx_t             a;  // upper input
      cplx_t             b;  // lower input, gets rotated
      logic [ang_w-1:0]  k;  // twiddle angle index
   } bfly_job_t;

   typedef struct packed {
      cplx_t x0;  // (a + w*b) / 2
      cplx_t x1;  // (a - w*b) / 2
   } bfly_res_t;

   typedef enum logic [2:0] {
      lane_idle,       // waiting for job_req
      lane_fetch,      // tw_req up, waiting for tw_ack
      lane_release,    // tw_req down, waiting for tw_ack to fall
      lane_compute,    // butterfly and res register
      lane_done,       // job_ack held until job_req falls
      lane_wait_drop   // one cycle gap after job_ack falls
   } lane_state_t;

   typedef enum logic [1:0] {
      arb_idle,  // looking for a request
      arb_read,  // rd_en pulse to the rom
      arb_ack,   // data wait, then tw_ack held
      arb_drop   // tw_ack released
   } arb_state_t;

endpackage

/* src/fft_stage_top.sv */
`timescale 1ns/1ps

module fft_stage_top #(
   parameter int fft_n = 32  // transform size for the twiddle stride
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic [1:0]         job_req,  // one per lane
   input  fft_pkg::bfly_job_t job0,
   input  fft_pkg::bfly_job_t job1,
   output logic [1:0]         job_ack,
   output fft_pkg::bfly_res_t res0,
   output fft_pkg::bfly_res_t res1
);
   import fft_pkg::*;

   logic [1:0]       tw_req;   // lane -> arbiter
   logic [1:0]       tw_ack;   // arbiter -> lane, one-hot
   logic [ang_w-1:0] tw_k0;
   logic [ang_w-1:0] tw_k1;
   twiddle_t         tw_data;  // shared twiddle to both lanes
   logic             rd_en;    // arbiter -> rom
   logic [ang_w-1:0] rd_k;
   twiddle_t         tw;       // rom -> arbiter

   butterfly_lane i_lane0 (
      .clk     (clk),
      .arst_n  (arst_n),
      .job_req (job_req[0]),
      .job     (job0),
      .job_ack (job_ack[0]),
      .res     (res0),
      .tw_req  (tw_req[0]),
      .tw_k    (tw_k0),
      .tw_ack  (tw_ack[0]),
      .tw_data (tw_data)
   );

   butterfly_lane i_lane1 (
      .clk     (clk),
      .arst_n  (arst_n),
      .job_req (job_req[1]),
      .job     (job1),
      .job_ack (job_ack[1]),
      .res     (res1),
      .tw_req  (tw_req[1]),
      .tw_k    (tw_k1),
      .tw_ack  (tw_ack[1]),
      .tw_data (tw_data)
   );

   twiddle_arbiter i_twiddle_arbiter (
      .clk     (clk),
      .arst_n  (arst_n),
      .tw_req  (tw_req),
      .tw_k0   (tw_k0),
      .tw_k1   (tw_k1),
      .tw_ack  (tw_ack),
      .tw_data (tw_data),
      .rd_en   (rd_en),
      .rd_k    (rd_k),
      .tw      (tw)
   );

   twiddle_rom #(
      .fft_n (fft_n)
   ) i_twiddle_rom (
      .clk   (clk),
      .rd_en (rd_en),
      .rd_k  (rd_k),
      .tw    (tw)
   );

endmodule

/* src/twiddle_arbiter.sv */
`timescale 1ns/1ps

module twiddle_arbiter (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic [1:0]                tw_req,   // one per lane
   input  logic [fft_pkg::ang_w-1:0] tw_k0,    // lane 0 angle
   input  logic [fft_pkg::ang_w-1:0] tw_k1,    // lane 1 angle
   output logic [1:0]                tw_ack,   // one-hot, four-phase
   output fft_pkg::twiddle_t         tw_data,  // shared, valid with tw_ack
   output logic                      rd_en,    // rom read strobe
   output logic [fft_pkg::ang_w-1:0] rd_k,     // rom angle index
   input  fft_pkg::twiddle_t         tw        // rom data
);
   import fft_pkg::*;

   arb_state_t state;
   logic       gnt;   // granted lane, kept as last grant when idle
   logic       pick;  // lane to grant from idle
   logic       take;  // grant happens this cycle

   // round robin between the two lanes
   always_comb begin
      if (tw_req == 2'b11) begin
         pick = ~gnt;  // tie goes to the lane not served last
      end else begin
         pick = tw_req[1];  // single requester
      end
   end

   assign take    = (state == arb_idle) && (|tw_req);
   assign tw_data = tw;  // only the acked lane latches it

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= arb_idle;
         gnt    <= 1'b1;  // lane 0 wins the first tie
         rd_en  <= 1'b0;
         tw_ack <= 2'b00;
      end else begin
         case (state)
            arb_idle: begin
               if (take) begin
                  gnt   <= pick;
                  rd_en <= 1'b1;  // one cycle pulse
                  state <= arb_read;
               end
            end
            arb_read: begin
               rd_en <= 1'b0;  // rom registers on this edge
               state <= arb_ack;
            end
            arb_ack: begin
               if (tw_ack == 2'b00) begin
                  tw_ack <= gnt ? 2'b10 : 2'b01;  // rom output settled
               end else if (!tw_req[gnt]) begin
                  tw_ack <= 2'b00;  // lane has latched, release
                  state  <= arb_drop;
               end
            end
            arb_drop: begin
               state <= arb_idle;  // other lane may go next
            end
            default: begin
               state <= arb_idle;
            end
         endcase
      end
   end

   // index of the granted lane, captured with the grant
   always_ff @(posedge clk) begin
      if (take) begin
         rd_k <= pick ? tw_k1 : tw_k0;
      end
   end

endmodule

/* src/twiddle_rom.sv */
`timescale 1ns/1ps

module twiddle_rom #(
   parameter int fft_n = 32  // transform size, power of two up to max_n
) (
   input  logic                      clk,
   input  logic                      rd_en,  // registered read strobe
   input  logic [fft_pkg::ang_w-1:0] rd_k,   // angle index for fft_n
   output fft_pkg::twiddle_t         tw      // cos/sin, one cycle after rd_en
);
   import fft_pkg::*;

   `include "twiddle_table.svh"

   // smaller transforms step through the 32-point table
   localparam int stride_sh = $clog2(max_n / fft_n);

   logic [ang_w-1:0] rd_ptr;  // index into the native table

   assign rd_ptr = ang_w'(rd_k << stride_sh);  // k * max_n/fft_n

   // rom macro style, output holds while rd_en low
   always_ff @(posedge clk) begin
      if (rd_en) begin
         tw.cos <= tw_cos_tab[rd_ptr];
         tw.sin <= tw_sin_tab[rd_ptr];
      end
   end

endmodule

/* src/twiddle_table.svh */
// q1.12 cos/sin of 2*pi*i/32, rounded to nearest
// index i covers the first half turn, 0 .. max_n/2-1

localparam logic signed [fft_pkg::tw_w-1:0] tw_cos_tab [0:fft_pkg::max_n/2-1] = '{
    14'sd4096,  14'sd4017,  14'sd3784,  14'sd3406,  // 0 .. 33.75 deg
    14'sd2896,  14'sd2276,  14'sd1567,  14'sd799,   // 45 .. 78.75 deg
    14'sd0,    -14'sd799,  -14'sd1567, -14'sd2276,  // 90 .. 123.75 deg
   -14'sd2896, -14'sd3406, -14'sd3784, -14'sd4017   // 135 .. 168.75 deg
};

localparam logic signed [fft_pkg::tw_w-1:0] tw_sin_tab [0:fft_pkg::max_n/2-1] = '{
    14'sd0,     14'sd799,   14'sd1567,  14'sd2276,  // rising quarter
    14'sd2896,  14'sd3406,  14'sd3784,  14'sd4017,
    14'sd4096,  14'sd4017,  14'sd3784,  14'sd3406,  // peak at 90 deg
    14'sd2896,  14'sd2276,  14'sd1567,  14'sd799    // falling back
};

// 4096 is exact 1.0 and still fits the 14-bit signed range
